/* files.f */
logic/lsu_pkg.sv
logic/lsu_ctrl.sv
logic/access_planner.sv
logic/axi_read_master.sv
logic/axi_write_master.sv
logic/load_merge.sv
logic/lsu_top.sv
verif/axi_mem_model.sv
verif/lsu_tb.sv

/* logic/access_planner.sv */
`timescale 1ns/10ps

module access_planner (
	input  lsu_pkg::lsu_req_t  req,
	output lsu_pkg::beat_t     first,
	output lsu_pkg::beat_t     second,
	output logic               two_beats,
	output logic [2:0]         size
);
	import lsu_pkg::*;

	logic [2:0]        nbytes;
	logic [addr_w-1:0] base_addr;

	assign size      = access_size(req.op);
	assign nbytes    = 3'd1 << size;
	assign base_addr = {req.addr[addr_w-1:2], 2'b00};

	// crossing a 4-byte boundary needs a second transfer
	assign two_beats = ({1'b0, req.addr[1:0]} + nbytes) > 3'd4;

	// ----------------------------------------------------------------------
	// lanes and strobes
	// ----------------------------------------------------------------------
	always_comb begin
		logic [2:0] lane;
		logic [2:0] pos;

		first.addr  = base_addr;
		first.strb  = '0;
		first.data  = '0;
		second.addr = base_addr + 32'd4;
		second.strb = '0;
		second.data = '0;
		for (int i = 0; i < 4; i++) begin
			lane = req.addr[2:0] + 3'(i);
			pos  = {1'b0, req.addr[1:0]} + 3'(i);
			if (3'(i) < nbytes) begin
				// bytes past the word boundary go on the second beat
				if (pos < 3'd4) begin
					first.strb[lane]         = 1'b1;
					first.data[lane*8 +: 8]  = req.wdata[i*8 +: 8];
				end else begin
					second.strb[lane]        = 1'b1;
					second.data[lane*8 +: 8] = req.wdata[i*8 +: 8];
				end
			end
		end
	end

endmodule

/* logic/axi_read_master.sv */
`timescale 1ns/10ps

module axi_read_master (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        rd_start,
	output logic                        rd_done,
	input  lsu_pkg::beat_t              first,
	input  lsu_pkg::beat_t              second,
	input  logic                        two_beats,
	input  logic [2:0]                  size,
	output lsu_pkg::ar_t                ar,
	output logic                        arvalid,
	input  logic                        arready,
	input  lsu_pkg::r_t                 r,
	input  logic                        rvalid,
	output logic                        rready,
	output logic [lsu_pkg::bus_w-1:0]   beat0_data,
	output logic [lsu_pkg::bus_w-1:0]   beat1_data
);
	import lsu_pkg::*;

	logic [1:0] state;
	logic       on_second;

	assign ar.addr = on_second ? second.addr : first.addr;
	assign ar.size = size;

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= rd_idle;
			on_second <= 1'b0;
			arvalid   <= 1'b0;
			rready    <= 1'b0;
			rd_done   <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			case (state)
				rd_idle: if (rd_start) begin
					arvalid   <= 1'b1;
					on_second <= 1'b0;
					state     <= rd_addr;
				end
				rd_addr: if (arready) begin
					arvalid <= 1'b0;
					rready  <= 1'b1;
					state   <= rd_data;
				end
				rd_data: if (rvalid) begin
					rready <= 1'b0;
					if (two_beats && !on_second) begin
						on_second <= 1'b1;
						state     <= rd_addr2;
					end else begin
						rd_done <= 1'b1;
						state   <= rd_idle;
					end
				end
				// one idle cycle between the two beats
				default: begin
					arvalid <= 1'b1;
					state   <= rd_addr;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (rvalid && rready) begin
			if (on_second)
				beat1_data <= r.data;
			else
				beat0_data <= r.data;
		end
	end

	a_ar_hold: assert property (@(posedge clock) disable iff (reset)
		(arvalid && !arready) |=> (arvalid && $stable(ar)));

endmodule

/* logic/axi_write_master.sv */
`timescale 1ns/10ps

module axi_write_master (
	input  logic              clock,
	input  logic              reset,
	input  logic              wr_start,
	output logic              wr_done,
	input  lsu_pkg::beat_t    first,
	input  lsu_pkg::beat_t    second,
	input  logic              two_beats,
	input  logic [2:0]        size,
	output lsu_pkg::aw_t      aw,
	output logic              awvalid,
	input  logic              awready,
	output lsu_pkg::w_t       w,
	output logic              wvalid,
	input  logic              wready,
	input  lsu_pkg::b_t       b,
	input  logic              bvalid,
	output logic              bready
);
	import lsu_pkg::*;

	logic [2:0] state;
	logic       on_second;

	// ----------------------------------------------------------------------
	// payload of the current beat
	// ----------------------------------------------------------------------
	assign aw.addr = on_second ? second.addr : first.addr;
	assign aw.size = size;
	assign w.data  = on_second ? second.data : first.data;
	assign w.strb  = on_second ? second.strb : first.strb;
	assign w.last  = 1'b1;

	// ----------------------------------------------------------------------
	// aw, w, b sequence per beat
	// ----------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= wr_idle;
			on_second <= 1'b0;
			awvalid   <= 1'b0;
			wvalid    <= 1'b0;
			bready    <= 1'b0;
			wr_done   <= 1'b0;
		end else begin
			wr_done <= 1'b0;
			case (state)
				wr_idle: if (wr_start) begin
					awvalid   <= 1'b1;
					on_second <= 1'b0;
					state     <= wr_addr;
				end
				wr_addr: if (awready) begin
					awvalid <= 1'b0;
					wvalid  <= 1'b1;
					state   <= wr_data;
				end
				wr_data: if (wready) begin
					wvalid <= 1'b0;
					bready <= 1'b1;
					state  <= wr_resp;
				end
				wr_resp: if (bvalid) begin
					bready <= 1'b0;
					// response code is not acted on
					if (two_beats && !on_second) begin
						on_second <= 1'b1;
						state     <= wr_addr2;
					end else begin
						wr_done <= 1'b1;
						state   <= wr_idle;
					end
				end
				wr_addr2: begin
					awvalid <= 1'b1;
					state   <= wr_addr;
				end
				default: state <= wr_idle;
			endcase
		end
	end

	// the planner never hands over a beat without bytes
	a_wstrb_set: assert property (@(posedge clock) disable iff (reset)
		wvalid |-> (w.strb != '0));

endmodule

/* logic/load_merge.sv */
`timescale 1ns/10ps

module load_merge (
	input  lsu_pkg::lsu_req_t             req,
	input  logic [lsu_pkg::bus_w-1:0]     beat0_data,
	input  logic [lsu_pkg::bus_w-1:0]     beat1_data,
	output logic [lsu_pkg::data_w-1:0]    load_value
);
	import lsu_pkg::*;

	logic [data_w-1:0] raw;

	// byte i from lane (addr + i) mod 8 of its beat
	always_comb begin
		logic [2:0] lane;
		logic [2:0] pos;

		raw = '0;
		for (int i = 0; i < 4; i++) begin
			lane = req.addr[2:0] + 3'(i);
			pos  = {1'b0, req.addr[1:0]} + 3'(i);
			if (pos < 3'd4)
				raw[i*8 +: 8] = beat0_data[lane*8 +: 8];
			else
				raw[i*8 +: 8] = beat1_data[lane*8 +: 8];
		end
	end

	// extension by operation
	always_comb begin
		case (req.op)
			op_lb:   load_value = {{24{raw[7]}}, raw[7:0]};
			op_lbu:  load_value = {24'd0, raw[7:0]};
			op_lh:   load_value = {{16{raw[15]}}, raw[15:0]};
			op_lhu:  load_value = {16'd0, raw[15:0]};
			op_lw:   load_value = raw;
			default: load_value = '0;
		endcase
	end

endmodule

/* logic/lsu_ctrl.sv */
`timescale 1ns/10ps

module lsu_ctrl (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          req_valid,
	output logic                          req_ready,
	input  lsu_pkg::lsu_req_t             req_in,
	output lsu_pkg::lsu_req_t             req,
	output logic                          rd_start,
	output logic                          wr_start,
	input  logic                          rd_done,
	input  logic                          wr_done,
	input  logic [lsu_pkg::data_w-1:0]    load_value,
	output logic                          resp_valid,
	input  logic                          resp_ready,
	output logic [lsu_pkg::data_w-1:0]    resp_data
);
	import lsu_pkg::*;

	logic busy;
	logic accept;

	// one request in flight, new one only once the response is gone
	assign req_ready = !busy;
	assign accept    = req_valid && req_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy       <= 1'b0;
			rd_start   <= 1'b0;
			wr_start   <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			rd_start <= accept && !is_store(req_in.op);
			wr_start <= accept && is_store(req_in.op);
			if (accept)
				busy <= 1'b1;
			else if (resp_valid && resp_ready)
				busy <= 1'b0;
			if (rd_done || wr_done)
				resp_valid <= 1'b1;
			else if (resp_ready)
				resp_valid <= 1'b0;
		end
	end

	// held request and response value
	always_ff @(posedge clock) begin
		if (accept)
			req <= req_in;
		if (rd_done)
			resp_data <= load_value;
		else if (wr_done)
			resp_data <= '0;
	end

	// a master may only finish while a request is open and unanswered
	a_done_when_busy: assert property (@(posedge clock) disable iff (reset)
		(rd_done || wr_done) |-> (busy && !resp_valid));

endmodule

/* logic/lsu_pkg.sv */
package lsu_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int bus_w  = 64;
	localparam int strb_w = 8;

	// read master states
	localparam logic [1:0] rd_idle  = 2'd0;
	localparam logic [1:0] rd_addr  = 2'd1;
	localparam logic [1:0] rd_data  = 2'd2;
	localparam logic [1:0] rd_addr2 = 2'd3;

	// write master states
	localparam logic [2:0] wr_idle  = 3'd0;
	localparam logic [2:0] wr_addr  = 3'd1;
	localparam logic [2:0] wr_data  = 3'd2;
	localparam logic [2:0] wr_resp  = 3'd3;
	localparam logic [2:0] wr_addr2 = 3'd4;

	typedef enum logic [2:0] {
		op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw
	} mem_op_t;

	// ----------------------------------------------------------------------
	// request, beat and bus channel payloads
	// ----------------------------------------------------------------------
	typedef struct packed {
		mem_op_t             op;
		logic [addr_w-1:0]   addr;
		logic [data_w-1:0]   wdata;
	} lsu_req_t;

	typedef struct packed {
		logic [addr_w-1:0]   addr;
		logic [strb_w-1:0]   strb;
		logic [bus_w-1:0]    data;
	} beat_t;

	typedef struct packed {
		logic [addr_w-1:0]   addr;
		logic [2:0]          size;
	} ar_t;

	typedef struct packed {
		logic [addr_w-1:0]   addr;
		logic [2:0]          size;
	} aw_t;

	typedef struct packed {
		logic [bus_w-1:0]    data;
		logic [strb_w-1:0]   strb;
		logic                last;
	} w_t;

	typedef struct packed {
		logic [bus_w-1:0]    data;
		logic [1:0]          resp;
	} r_t;

	typedef struct packed {
		logic [1:0]          resp;
	} b_t;

	// log2 of the access size in bytes, also the axi size code
	function automatic logic [2:0] access_size(mem_op_t op);
		case (op)
			op_lb, op_lbu, op_sb: return 3'd0;
			op_lh, op_lhu, op_sh: return 3'd1;
			default:              return 3'd2;
		endcase
	endfunction

	function automatic logic is_store(mem_op_t op);
		return (op == op_sb) || (op == op_sh) || (op == op_sw);
	endfunction

endpackage

/* logic/lsu_top.sv */
`timescale 1ns/10ps

module lsu_top (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          req_valid,
	output logic                          req_ready,
	input  lsu_pkg::lsu_req_t             req,
	output logic                          resp_valid,
	input  logic                          resp_ready,
	output logic [lsu_pkg::data_w-1:0]    resp_data,
	output lsu_pkg::ar_t                  ar,
	output logic                          arvalid,
	input  logic                          arready,
	input  lsu_pkg::r_t                   r,
	input  logic                          rvalid,
	output logic                          rready,
	output lsu_pkg::aw_t                  aw,
	output logic                          awvalid,
	input  logic                          awready,
	output lsu_pkg::w_t                   w,
	output logic                          wvalid,
	input  logic                          wready,
	input  lsu_pkg::b_t                   b,
	input  logic                          bvalid,
	output logic                          bready
);
	import lsu_pkg::*;

	lsu_req_t          held_req;
	beat_t             first;
	beat_t             second;
	logic              two_beats;
	logic [2:0]        size;
	logic              rd_start, rd_done;
	logic              wr_start, wr_done;
	logic [bus_w-1:0]  beat0_data, beat1_data;
	logic [data_w-1:0] load_value;

	lsu_ctrl i_ctrl (
		.clock, .reset, .req_valid, .req_ready, .req_in(req), .req(held_req),
		.rd_start, .wr_start, .rd_done, .wr_done, .load_value,
		.resp_valid, .resp_ready, .resp_data
	);

	access_planner i_planner (
		.req(held_req), .first, .second, .two_beats, .size
	);

	axi_read_master i_rd (
		.clock, .reset, .rd_start, .rd_done, .first, .second, .two_beats, .size,
		.ar, .arvalid, .arready, .r, .rvalid, .rready, .beat0_data, .beat1_data
	);

	axi_write_master i_wr (
		.clock, .reset, .wr_start, .wr_done, .first, .second, .two_beats, .size,
		.aw, .awvalid, .awready, .w, .wvalid, .wready, .b, .bvalid, .bready
	);

	load_merge i_merge (
		.req(held_req), .beat0_data, .beat1_data, .load_value
	);

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f files.f -o lsu_sim
output=$(./obj_dir/lsu_sim)
echo "$output"
if echo "$output" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1

/* verif/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model (
	input  logic            clock,
	input  logic            reset,
	input  lsu_pkg::ar_t    ar,
	input  logic            arvalid,
	output logic            arready,
	output lsu_pkg::r_t     r,
	output logic            rvalid,
	input  logic            rready,
	input  lsu_pkg::aw_t    aw,
	input  logic            awvalid,
	output logic            awready,
	input  lsu_pkg::w_t     w,
	input  logic            wvalid,
	output logic            wready,
	output lsu_pkg::b_t     b,
	output logic            bvalid,
	input  logic            bready,
	output logic [2:0]      rd_size,
	output logic [2:0]      wr_size,
	output logic            wr_last,
	output int              rd_count,
	output int              wr_count,
	output int              stuck_count
);
	import lsu_pkg::*;

	// 256 bytes, upper address bits ignored
	logic [7:0]  mem [0:255];
	logic [31:0] rd_rng = 32'h5d8f_a6fc;
	logic [31:0] wr_rng = 32'h5d8f_a6fc;
	int          rd_stuck = 0;
	int          wr_stuck = 0;

	assign stuck_count = rd_stuck + wr_stuck;

	function automatic logic [7:0] initial_byte(input logic [7:0] a);
		return (a * 8'd37) ^ {a[3:0], a[7:4]} ^ 8'h5a;
	endfunction

	function automatic logic [31:0] xorshift_next(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// lane l of a beat holds the byte at the 8-byte block base plus l
	function automatic logic [63:0] read_lanes(input logic [31:0] a);
		logic [63:0] d;
		logic [7:0]  blk;
		blk = {a[7:3], 3'b000};
		for (int l = 0; l < 8; l++)
			d[l*8 +: 8] = mem[blk + 8'(l)];
		return d;
	endfunction

	// ----------------------------------------------------------------------
	// read channel, one beat at a time
	// ----------------------------------------------------------------------
	initial begin : read_channel
		logic [31:0] a;
		int          n;
		arready  = 1'b0;
		rvalid   = 1'b0;
		r        = '0;
		rd_size  = '0;
		rd_count = 0;
		forever begin
			@(negedge clock);
			if (!reset && arvalid) begin
				a = ar.addr;
				rd_size = ar.size;
				rd_rng = xorshift_next(rd_rng);
				repeat (int'(rd_rng[5:4])) @(negedge clock);
				arready = 1'b1;
				@(negedge clock);
				arready = 1'b0;
				rd_count++;
				rd_rng = xorshift_next(rd_rng);
				repeat (int'(rd_rng[5:4])) @(negedge clock);
				r.data = read_lanes(a);
				r.resp = 2'b00;
				rvalid = 1'b1;
				n = 0;
				while (!rready && n < 100) begin
					@(negedge clock);
					n++;
				end
				if (rready)
					@(negedge clock);
				else
					rd_stuck++;
				rvalid = 1'b0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// write channel, aw then w then b
	// ----------------------------------------------------------------------
	initial begin : write_channel
		logic [31:0] a;
		logic [63:0] d;
		logic [7:0]  s;
		logic [7:0]  blk;
		int          n;
		awready  = 1'b0;
		wready   = 1'b0;
		bvalid   = 1'b0;
		b        = '0;
		wr_size  = '0;
		wr_last  = 1'b0;
		wr_count = 0;
		for (int i = 0; i < 256; i++)
			mem[i] = initial_byte(8'(i));
		forever begin
			@(negedge clock);
			if (!reset && awvalid) begin
				a = aw.addr;
				wr_size = aw.size;
				wr_rng = xorshift_next(wr_rng);
				repeat (int'(wr_rng[5:4])) @(negedge clock);
				awready = 1'b1;
				@(negedge clock);
				awready = 1'b0;
				wr_count++;
				n = 0;
				while (!wvalid && n < 100) begin
					@(negedge clock);
					n++;
				end
				if (!wvalid) begin
					wr_stuck++;
				end else begin
					d = w.data;
					s = w.strb;
					wr_last = w.last;
					wr_rng = xorshift_next(wr_rng);
					repeat (int'(wr_rng[5:4])) @(negedge clock);
					wready = 1'b1;
					@(negedge clock);
					wready = 1'b0;
					blk = {a[7:3], 3'b000};
					for (int l = 0; l < 8; l++)
						if (s[l])
							mem[blk + 8'(l)] = d[l*8 +: 8];
					wr_rng = xorshift_next(wr_rng);
					repeat (int'(wr_rng[5:4])) @(negedge clock);
					b.resp = 2'b00;
					bvalid = 1'b1;
					n = 0;
					while (!bready && n < 100) begin
						@(negedge clock);
						n++;
					end
					if (bready)
						@(negedge clock);
					else
						wr_stuck++;
					bvalid = 1'b0;
				end
			end
		end
	end

endmodule

/* verif/lsu_tb.sv */
`timescale 1ns/10ps

module lsu_tb;
	import lsu_pkg::*;

	typedef struct packed {
		mem_op_t     op;
		logic [31:0] addr;
		logic [31:0] value;
		logic [1:0]  beats;
		logic [3:0]  hold;
	} expect_t;

	logic        clock = 1'b0;
	logic        reset;
	logic        req_valid;
	logic        req_ready;
	lsu_req_t    req;
	logic        resp_valid;
	logic        resp_ready = 1'b0;
	logic [31:0] resp_data;
	ar_t         ar;
	logic        arvalid;
	logic        arready;
	r_t          r;
	logic        rvalid;
	logic        rready;
	aw_t         aw;
	logic        awvalid;
	logic        awready;
	w_t          w;
	logic        wvalid;
	logic        wready;
	b_t          b;
	logic        bvalid;
	logic        bready;
	logic [2:0]  rd_size;
	logic [2:0]  wr_size;
	logic        wr_last;
	int          rd_count;
	int          wr_count;
	int          stuck_count;

	logic [7:0]  shadow [0:255];
	logic [31:0] rng;
	expect_t     exp_q[$];
	logic        timed_out = 1'b0;
	int          checks = 0;
	int          mismatches = 0;
	int          failures = 0;
	int          waited = 0;
	int          last_rd = 0;
	int          last_wr = 0;

	lsu_top i_dut (.*);

	axi_mem_model i_mem (.*);

	always #4 clock = ~clock;

	// ----------------------------------------------------------------------
	// random numbers and reference model
	// ----------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// same fill as the memory model starts with
	function automatic logic [7:0] initial_byte(input logic [7:0] a);
		return (a * 8'd37) ^ {a[3:0], a[7:4]} ^ 8'h5a;
	endfunction

	function automatic int op_bytes(input mem_op_t op);
		case (op)
			op_lb, op_lbu, op_sb: return 1;
			op_lh, op_lhu, op_sh: return 2;
			default:              return 4;
		endcase
	endfunction

	// bus size code for byte, half and word
	function automatic logic [2:0] size_code(input mem_op_t op);
		case (op_bytes(op))
			1:       return 3'd0;
			2:       return 3'd1;
			default: return 3'd2;
		endcase
	endfunction

	function automatic logic [1:0] beat_count(input mem_op_t op, input logic [31:0] addr);
		return (int'(addr[1:0]) + op_bytes(op) > 4) ? 2'd2 : 2'd1;
	endfunction

	function automatic logic [31:0] expected_load(input mem_op_t op, input logic [31:0] addr);
		logic [31:0] raw;
		logic [7:0]  idx;
		raw = '0;
		for (int i = 0; i < op_bytes(op); i++) begin
			idx = addr[7:0] + 8'(i);
			raw[i*8 +: 8] = shadow[idx];
		end
		case (op)
			op_lb:   return {{24{raw[7]}}, raw[7:0]};
			op_lbu:  return {24'd0, raw[7:0]};
			op_lh:   return {{16{raw[15]}}, raw[15:0]};
			op_lhu:  return {16'd0, raw[15:0]};
			default: return raw;
		endcase
	endfunction

	function automatic void apply_store(input mem_op_t op, input logic [31:0] addr,
			input logic [31:0] data);
		logic [7:0] idx;
		for (int i = 0; i < op_bytes(op); i++) begin
			idx = addr[7:0] + 8'(i);
			shadow[idx] = data[i*8 +: 8];
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	task automatic issue(input mem_op_t op, input logic [31:0] addr, input logic [31:0] data);
		expect_t     e;
		logic [31:0] x;
		int          n;
		if (timed_out)
			return;
		n = 0;
		while (!req_ready && n < 200) begin
			@(negedge clock);
			n++;
		end
		if (!req_ready) begin
			$display("timeout at %0t: req_ready stayed low for %0d cycles", $time, n);
			failures++;
			timed_out = 1'b1;
			return;
		end
		x       = next_rand();
		e.op    = op;
		e.addr  = addr;
		e.beats = beat_count(op, addr);
		e.hold  = {1'b0, x[2:0]};
		if (op inside {op_sb, op_sh, op_sw}) begin
			e.value = '0;
			apply_store(op, addr, data);
		end else begin
			e.value = expected_load(op, addr);
		end
		exp_q.push_back(e);
		req.op    = op;
		req.addr  = addr;
		req.wdata = data;
		req_valid = 1'b1;
		@(negedge clock);
		req_valid = 1'b0;
		repeat (int'(x[5:4])) @(negedge clock);
	endtask

	task automatic check_reset_state();
		check_value("req_ready", 32'(req_ready), 32'd1);
		check_value("resp_valid", 32'(resp_valid), 32'd0);
		check_value("arvalid", 32'(arvalid), 32'd0);
		check_value("rready", 32'(rready), 32'd0);
		check_value("awvalid", 32'(awvalid), 32'd0);
		check_value("wvalid", 32'(wvalid), 32'd0);
		check_value("bready", 32'(bready), 32'd0);
	endtask

	task automatic directed_sequence();
		// aligned stores, then every load flavor over them
		issue(op_sw, 32'h40, 32'h8765_43f1);
		issue(op_sh, 32'h44, 32'h0000_9abc);
		issue(op_sb, 32'h47, 32'h0000_00c3);
		issue(op_lw, 32'h40, 32'h0);
		issue(op_lb, 32'h40, 32'h0);
		issue(op_lbu, 32'h40, 32'h0);
		issue(op_lh, 32'h42, 32'h0);
		issue(op_lhu, 32'h42, 32'h0);
		issue(op_lh, 32'h44, 32'h0);
		issue(op_lhu, 32'h44, 32'h0);
		issue(op_lb, 32'h47, 32'h0);
		issue(op_lbu, 32'h47, 32'h0);
		issue(op_lw, 32'h44, 32'h0);
		// accesses across word and 8-byte boundaries
		issue(op_sw, 32'h53, 32'hdead_beef);
		issue(op_sw, 32'h5e, 32'h1234_5678);
		issue(op_sh, 32'h67, 32'h0000_a55a);
		issue(op_sh, 32'h6b, 32'h0000_80ff);
		issue(op_lw, 32'h53, 32'h0);
		issue(op_lw, 32'h5e, 32'h0);
		issue(op_lh, 32'h67, 32'h0);
		issue(op_lhu, 32'h6b, 32'h0);
		issue(op_lw, 32'h51, 32'h0);
		issue(op_lh, 32'h6a, 32'h0);
		issue(op_lw, 32'h60, 32'h0);
	endtask

	task automatic random_mix(input int count);
		logic [31:0] x;
		mem_op_t     op;
		logic [31:0] addr;
		for (int i = 0; i < count; i++) begin
			x    = next_rand();
			op   = mem_op_t'(x[2:0]);
			addr = next_rand() % 32'd252;
			issue(op, addr, next_rand());
		end
	endtask

	// every word of the memory compared against the shadow
	task automatic readback_memory();
		for (int a = 0; a < 256; a += 4)
			issue(op_lw, 32'(a), 32'h0);
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || !req_ready) && n < 500) begin
			@(negedge clock);
			n++;
		end
		if (exp_q.size() != 0 || !req_ready) begin
			$display("timeout at %0t: %0d responses still outstanding", $time, exp_q.size());
			failures++;
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, mismatches %0d, other errors %0d, stuck channels %0d",
			checks, mismatches, failures, stuck_count);
		if (mismatches == 0 && failures == 0 && stuck_count == 0 && checks > 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	initial begin : main
		rng       = 32'h5d8f_a6fc;
		reset     = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		for (int a = 0; a < 256; a++)
			shadow[a] = initial_byte(8'(a));
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check_reset_state();
		directed_sequence();
		random_mix(300);
		readback_memory();
		drain();
		finish_run();
	end

	// ----------------------------------------------------------------------
	// response side, back-pressure and compare
	// ----------------------------------------------------------------------
	always @(negedge clock) begin : compare
		expect_t e;
		logic    store;
		if (reset) begin
			resp_ready = 1'b0;
			waited     = 0;
			last_rd    = rd_count;
			last_wr    = wr_count;
		end else if (!resp_valid) begin
			resp_ready = 1'b0;
		end else if (exp_q.size() == 0) begin
			$display("response at %0t with no request outstanding", $time);
			failures++;
			resp_ready = 1'b1;
		end else if (waited < int'(exp_q[0].hold)) begin
			// hold the response off for a few cycles
			resp_ready = 1'b0;
			waited++;
		end else begin
			e     = exp_q.pop_front();
			store = e.op inside {op_sb, op_sh, op_sw};
			check_value("resp_data", resp_data, e.value);
			check_value("ar transfers", 32'(rd_count - last_rd), store ? 32'd0 : 32'(e.beats));
			check_value("aw transfers", 32'(wr_count - last_wr), store ? 32'(e.beats) : 32'd0);
			if (store) begin
				check_value("aw size", 32'(wr_size), 32'(size_code(e.op)));
				check_value("w last", 32'(wr_last), 32'd1);
			end else begin
				check_value("ar size", 32'(rd_size), 32'(size_code(e.op)));
			end
			last_rd    = rd_count;
			last_wr    = wr_count;
			resp_ready = 1'b1;
			waited     = 0;
		end
	end

endmodule
